// ==== build.f ====
isb_pkg.sv
training_unit.sv
ps_amc.sv
sp_amc.sv
isb_trainer.sv
stream_predictor.sv
isb_top.sv
isb_checker.sv
tb_isb.sv

// ==== isb_checker.sv ====
`default_nettype none

module isb_checker (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            access_v_i,
    input  isb_pkg::pc_t    access_pc_i,
    input  isb_pkg::paddr_t access_addr_i,
    input  logic            prefetch_v_i,
    input  isb_pkg::paddr_t prefetch_addr_i,
    output int              mismatch_count_o,
    output int              prefetch_count_o
);
    import isb_pkg::*;

    // training unit model, a larger stamp means more recently used
    logic   tu_v [TU_ENTRIES];
    pc_t    tu_pc [TU_ENTRIES];
    paddr_t tu_addr [TU_ENTRIES];
    int     tu_stamp [TU_ENTRIES];
    int     stamp_now;

    logic   ps_v [PS_ENTRIES];
    paddr_t ps_tag [PS_ENTRIES];
    int     ps_sa [PS_ENTRIES];
    int     ps_conf [PS_ENTRIES];

    // block number held by each sp entry, -1 when never written
    int     sp_blk [SP_ENTRIES];
    logic   sp_v [SP_ENTRIES][SP_SLOTS];
    paddr_t sp_pa [SP_ENTRIES][SP_SLOTS];

    int     next_sa;
    logic   exp_v;
    paddr_t exp_addr;
    logic   armed;

    initial begin
        mismatch_count_o = 0;
        prefetch_count_o = 0;
        armed = 1'b0;
        exp_v = 1'b0;
        exp_addr = '0;
    end

    function automatic logic ps_hit(input paddr_t addr);
        return ps_v[addr % PS_ENTRIES] && ps_tag[addr % PS_ENTRIES] == addr;
    endfunction

    task automatic ps_write(input paddr_t addr, input int sa, input int conf);
        int idx;
        idx = addr % PS_ENTRIES;
        ps_v[idx] = 1'b1;
        ps_tag[idx] = addr;
        ps_sa[idx] = sa;
        ps_conf[idx] = conf;
    endtask

    task automatic sp_write(input int sa, input paddr_t pa);
        int blk;
        int slot;
        blk = sa / SP_SLOTS;
        slot = sa % SP_SLOTS;
        // another block in this entry is thrown away
        if (sp_blk[blk % SP_ENTRIES] != blk) begin
            sp_blk[blk % SP_ENTRIES] = blk;
            for (int s = 0; s < SP_SLOTS; s++) begin
                sp_v[blk % SP_ENTRIES][s] = 1'b0;
            end
        end
        sp_v[blk % SP_ENTRIES][slot] = 1'b1;
        sp_pa[blk % SP_ENTRIES][slot] = pa;
    endtask

    // a mapping lands in both tables, never past the structural space
    task automatic map_addr(input int sa, input paddr_t pa);
        if (sa < SA_SPACE) begin
            ps_write(pa, sa, CONF_MAX);
            sp_write(sa, pa);
        end
    endtask

    task automatic bump_alloc;
        next_sa = (next_sa + STREAM_CHUNK > SA_SPACE) ? SA_SPACE : next_sa + STREAM_CHUNK;
    endtask

    task automatic train_pair(input paddr_t a, input paddr_t b);
        logic a_hit;
        logic b_hit;
        int   a_sa;
        int   b_sa;
        int   b_conf;
        a_hit = ps_hit(a);
        b_hit = ps_hit(b);
        a_sa = ps_sa[a % PS_ENTRIES];
        b_sa = ps_sa[b % PS_ENTRIES];
        b_conf = ps_conf[b % PS_ENTRIES];
        // a is always written before b so b wins a shared index
        if (!a_hit && !b_hit) begin
            map_addr(next_sa, a);
            map_addr(next_sa + 1, b);
            bump_alloc();
        end else if (!a_hit && b_hit) begin
            map_addr(next_sa, a);
            if (b_conf == 1) begin
                map_addr(next_sa + 1, b);
            end else begin
                ps_write(b, b_sa, b_conf - 1);
            end
            bump_alloc();
        end else if (a_hit && !b_hit) begin
            map_addr(a_sa + 1, b);
        end else if (b_sa == a_sa + 1) begin
            ps_write(b, b_sa, (b_conf + 1 > CONF_MAX) ? CONF_MAX : b_conf + 1);
        end else if (b_conf == 1) begin
            map_addr(a_sa + 1, b);
        end else begin
            ps_write(b, b_sa, b_conf - 1);
        end
    endtask

    task automatic reset_model;
        for (int i = 0; i < TU_ENTRIES; i++) begin
            tu_v[i] = 1'b0;
            tu_stamp[i] = i;
        end
        stamp_now = TU_ENTRIES;
        for (int i = 0; i < PS_ENTRIES; i++) begin
            ps_v[i] = 1'b0;
        end
        for (int i = 0; i < SP_ENTRIES; i++) begin
            sp_blk[i] = -1;
            for (int s = 0; s < SP_SLOTS; s++) begin
                sp_v[i][s] = 1'b0;
            end
        end
        next_sa = 0;
    endtask

    task automatic step_model;
        logic hit_tu;
        int   idx;
        int   nxt;
        exp_v = 1'b0;
        // prediction sees the tables before this access trains them
        if (access_v_i && ps_hit(access_addr_i)) begin
            nxt = ps_sa[access_addr_i % PS_ENTRIES] + 1;
            if (nxt < SA_SPACE && sp_blk[nxt / SP_SLOTS] == nxt / SP_SLOTS
                    && sp_v[nxt / SP_SLOTS][nxt % SP_SLOTS]) begin
                exp_v = 1'b1;
                exp_addr = sp_pa[nxt / SP_SLOTS][nxt % SP_SLOTS];
                prefetch_count_o++;
            end
        end
        hit_tu = 1'b0;
        idx = 0;
        for (int i = 0; i < TU_ENTRIES; i++) begin
            if (tu_v[i] && tu_pc[i] == access_pc_i) begin
                hit_tu = 1'b1;
                idx = i;
            end
        end
        if (!hit_tu) begin
            for (int i = 1; i < TU_ENTRIES; i++) begin
                if (tu_stamp[i] < tu_stamp[idx]) begin
                    idx = i;
                end
            end
        end
        if (access_v_i && hit_tu && tu_addr[idx] != access_addr_i) begin
            train_pair(tu_addr[idx], access_addr_i);
        end
        if (access_v_i) begin
            tu_v[idx] = 1'b1;
            tu_pc[idx] = access_pc_i;
            tu_addr[idx] = access_addr_i;
            tu_stamp[idx] = stamp_now;
            stamp_now++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_i) begin
            reset_model();
            exp_v = 1'b0;
            armed = 1'b1;
        end else if (armed) begin
            step_model();
        end
    end

    // outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        if (armed) begin
            if (prefetch_v_i !== exp_v) begin
                mismatch_count_o++;
                $display("FAILED time=%0t signal=prefetch_v_o expected=%0b actual=%0b",
                         $time, exp_v, prefetch_v_i);
            end else if (exp_v && prefetch_addr_i !== exp_addr) begin
                mismatch_count_o++;
                $display("FAILED time=%0t signal=prefetch_addr_o expected=%h actual=%h",
                         $time, exp_addr, prefetch_addr_i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== isb_pkg.sv ====
`default_nettype none

package isb_pkg;

    // training unit geometry
    localparam int TU_ENTRIES = 4;
    localparam int TU_IDX_W = 2;

    // physical-to-structural table, direct mapped on the low address bits
    localparam int PS_ENTRIES = 32;
    localparam int PS_IDX_W = 5;

    // structural-to-physical table, four slots per block
    localparam int SP_ENTRIES = 8;
    localparam int SP_SLOTS = 4;
    localparam int SP_IDX_W = 3;
    localparam int SLOT_W = 2;

    // structural address allocation
    localparam int SA_SPACE = 32;
    localparam int STREAM_CHUNK = 16;

    // confidence counter start and ceiling
    localparam int CONF_MAX = 3;

    typedef logic [15:0] pc_t;
    typedef logic [15:0] paddr_t;

    // one bit wider than the space so the saturated value 32 fits
    typedef logic [5:0] saddr_t;

    typedef logic [1:0] conf_t;

    typedef struct packed {
        logic   valid;
        paddr_t tag;
        saddr_t sa;
        conf_t  conf;
    } ps_entry_t;

endpackage

`default_nettype wire

// ==== isb_top.sv ====
`default_nettype none

module isb_top (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            access_v_i,
    input  isb_pkg::pc_t    access_pc_i,
    input  isb_pkg::paddr_t access_addr_i,
    output logic            prefetch_v_o,
    output isb_pkg::paddr_t prefetch_addr_o
);
    import isb_pkg::*;

    logic   tu_hit;
    paddr_t tu_last;

    logic   a_hit;
    logic   b_hit;
    saddr_t a_sa;
    saddr_t b_sa;
    conf_t  b_conf;

    logic   ps_wr_a;
    logic   ps_wr_b;
    paddr_t ps_wr_a_addr;
    paddr_t ps_wr_b_addr;
    saddr_t ps_wr_a_sa;
    saddr_t ps_wr_b_sa;
    conf_t  ps_wr_b_conf;

    logic   sp_wr0;
    logic   sp_wr1;
    saddr_t sp_wr0_sa;
    saddr_t sp_wr1_sa;
    paddr_t sp_wr0_pa;
    paddr_t sp_wr1_pa;

    saddr_t sp_rd_sa;
    logic   sp_rd_v;
    paddr_t sp_rd_pa;

    training_unit u_tu (
        .clk          (clk),
        .rst_i        (rst_i),
        .access_v_i   (access_v_i),
        .access_pc_i  (access_pc_i),
        .access_addr_i(access_addr_i),
        .tu_hit_o     (tu_hit),
        .tu_last_o    (tu_last)
    );

    // port a looks up the previous address, port b the current one
    ps_amc u_ps (
        .clk        (clk),
        .rst_i      (rst_i),
        .rd_a_addr_i(tu_last),
        .rd_b_addr_i(access_addr_i),
        .rd_a_hit_o (a_hit),
        .rd_b_hit_o (b_hit),
        .rd_a_sa_o  (a_sa),
        .rd_b_sa_o  (b_sa),
        .rd_b_conf_o(b_conf),
        .wr_a_i     (ps_wr_a),
        .wr_b_i     (ps_wr_b),
        .wr_a_addr_i(ps_wr_a_addr),
        .wr_b_addr_i(ps_wr_b_addr),
        .wr_a_sa_i  (ps_wr_a_sa),
        .wr_b_sa_i  (ps_wr_b_sa),
        .wr_b_conf_i(ps_wr_b_conf)
    );

    sp_amc u_sp (
        .clk     (clk),
        .rst_i   (rst_i),
        .wr0_i   (sp_wr0),
        .wr1_i   (sp_wr1),
        .wr0_sa_i(sp_wr0_sa),
        .wr1_sa_i(sp_wr1_sa),
        .wr0_pa_i(sp_wr0_pa),
        .wr1_pa_i(sp_wr1_pa),
        .rd_sa_i (sp_rd_sa),
        .rd_v_o  (sp_rd_v),
        .rd_pa_o (sp_rd_pa)
    );

    isb_trainer u_trainer (
        .clk           (clk),
        .rst_i         (rst_i),
        .access_v_i    (access_v_i),
        .tu_hit_i      (tu_hit),
        .tu_last_i     (tu_last),
        .access_addr_i (access_addr_i),
        .a_hit_i       (a_hit),
        .b_hit_i       (b_hit),
        .a_sa_i        (a_sa),
        .b_sa_i        (b_sa),
        .b_conf_i      (b_conf),
        .ps_wr_a_o     (ps_wr_a),
        .ps_wr_b_o     (ps_wr_b),
        .ps_wr_a_addr_o(ps_wr_a_addr),
        .ps_wr_b_addr_o(ps_wr_b_addr),
        .ps_wr_a_sa_o  (ps_wr_a_sa),
        .ps_wr_b_sa_o  (ps_wr_b_sa),
        .ps_wr_b_conf_o(ps_wr_b_conf),
        .sp_wr0_o      (sp_wr0),
        .sp_wr1_o      (sp_wr1),
        .sp_wr0_sa_o   (sp_wr0_sa),
        .sp_wr1_sa_o   (sp_wr1_sa),
        .sp_wr0_pa_o   (sp_wr0_pa),
        .sp_wr1_pa_o   (sp_wr1_pa)
    );

    stream_predictor u_pred (
        .clk            (clk),
        .rst_i          (rst_i),
        .access_v_i     (access_v_i),
        .b_hit_i        (b_hit),
        .b_sa_i         (b_sa),
        .sp_rd_sa_o     (sp_rd_sa),
        .sp_rd_v_i      (sp_rd_v),
        .sp_rd_pa_i     (sp_rd_pa),
        .prefetch_v_o   (prefetch_v_o),
        .prefetch_addr_o(prefetch_addr_o)
    );

endmodule

`default_nettype wire

// ==== isb_trainer.sv ====
`default_nettype none

module isb_trainer (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            access_v_i,
    input  logic            tu_hit_i,
    input  isb_pkg::paddr_t tu_last_i,
    input  isb_pkg::paddr_t access_addr_i,
    input  logic            a_hit_i,
    input  logic            b_hit_i,
    input  isb_pkg::saddr_t a_sa_i,
    input  isb_pkg::saddr_t b_sa_i,
    input  isb_pkg::conf_t  b_conf_i,
    output logic            ps_wr_a_o,
    output logic            ps_wr_b_o,
    output isb_pkg::paddr_t ps_wr_a_addr_o,
    output isb_pkg::paddr_t ps_wr_b_addr_o,
    output isb_pkg::saddr_t ps_wr_a_sa_o,
    output isb_pkg::saddr_t ps_wr_b_sa_o,
    output isb_pkg::conf_t  ps_wr_b_conf_o,
    output logic            sp_wr0_o,
    output logic            sp_wr1_o,
    output isb_pkg::saddr_t sp_wr0_sa_o,
    output isb_pkg::saddr_t sp_wr1_sa_o,
    output isb_pkg::paddr_t sp_wr0_pa_o,
    output isb_pkg::paddr_t sp_wr1_pa_o
);
    import isb_pkg::*;

    saddr_t next_sa;
    saddr_t a_succ;
    saddr_t b_tgt;
    conf_t  b_conf_new;
    logic   train;
    logic   do_alloc;
    logic   map_b_req;
    logic   ctr_b;
    logic   map_a;
    logic   map_b;

    // a known pc touching a different address
    assign train = access_v_i && tu_hit_i && tu_last_i != access_addr_i;
    assign a_succ = a_sa_i + 1'b1;

    always_comb begin
        do_alloc = 1'b0;
        map_b_req = 1'b0;
        ctr_b = 1'b0;
        b_tgt = a_succ;
        b_conf_new = b_conf_i;
        if (train) begin
            case ({a_hit_i, b_hit_i})
                2'b00: begin
                    // new pair starts a stream
                    do_alloc = 1'b1;
                    map_b_req = 1'b1;
                    b_tgt = next_sa + 1'b1;
                end
                2'b01: begin
                    do_alloc = 1'b1;
                    if (b_conf_i == conf_t'(1)) begin
                        map_b_req = 1'b1;
                        b_tgt = next_sa + 1'b1;
                    end else begin
                        ctr_b = 1'b1;
                        b_conf_new = b_conf_i - 1'b1;
                    end
                end
                2'b10: begin
                    // extend a's stream by one
                    map_b_req = 1'b1;
                end
                default: begin
                    if (b_sa_i == a_succ) begin
                        ctr_b = 1'b1;
                        if (b_conf_i != conf_t'(CONF_MAX)) begin
                            b_conf_new = b_conf_i + 1'b1;
                        end
                    end else if (b_conf_i == conf_t'(1)) begin
                        map_b_req = 1'b1;
                    end else begin
                        ctr_b = 1'b1;
                        b_conf_new = b_conf_i - 1'b1;
                    end
                end
            endcase
        end
    end

    // no mapping past the structural space
    assign map_a = do_alloc && next_sa < SA_SPACE;
    assign map_b = map_b_req && b_tgt < SA_SPACE;

    assign ps_wr_a_o = map_a;
    assign ps_wr_a_addr_o = tu_last_i;
    assign ps_wr_a_sa_o = next_sa;

    assign ps_wr_b_o = map_b || ctr_b;
    assign ps_wr_b_addr_o = access_addr_i;
    assign ps_wr_b_sa_o = map_b ? b_tgt : b_sa_i;
    assign ps_wr_b_conf_o = map_b ? conf_t'(CONF_MAX) : b_conf_new;

    assign sp_wr0_o = map_a;
    assign sp_wr0_sa_o = next_sa;
    assign sp_wr0_pa_o = tu_last_i;

    assign sp_wr1_o = map_b;
    assign sp_wr1_sa_o = b_tgt;
    assign sp_wr1_pa_o = access_addr_i;

    // allocator saturates at the end of the space
    always_ff @(posedge clk) begin
        if (rst_i) begin
            next_sa <= '0;
        end else if (do_alloc) begin
            if (next_sa >= SA_SPACE - STREAM_CHUNK) begin
                next_sa <= saddr_t'(SA_SPACE);
            end else begin
                next_sa <= next_sa + saddr_t'(STREAM_CHUNK);
            end
        end
    end

endmodule

`default_nettype wire

// ==== ps_amc.sv ====
`default_nettype none

module ps_amc (
    input  logic            clk,
    input  logic            rst_i,
    input  isb_pkg::paddr_t rd_a_addr_i,
    input  isb_pkg::paddr_t rd_b_addr_i,
    output logic            rd_a_hit_o,
    output logic            rd_b_hit_o,
    output isb_pkg::saddr_t rd_a_sa_o,
    output isb_pkg::saddr_t rd_b_sa_o,
    output isb_pkg::conf_t  rd_b_conf_o,
    input  logic            wr_a_i,
    input  logic            wr_b_i,
    input  isb_pkg::paddr_t wr_a_addr_i,
    input  isb_pkg::paddr_t wr_b_addr_i,
    input  isb_pkg::saddr_t wr_a_sa_i,
    input  isb_pkg::saddr_t wr_b_sa_i,
    input  isb_pkg::conf_t  wr_b_conf_i
);
    import isb_pkg::*;

    ps_entry_t ps_mem [PS_ENTRIES];
    ps_entry_t ent_a;
    ps_entry_t ent_b;
    ps_entry_t new_a;
    ps_entry_t new_b;

    assign ent_a = ps_mem[rd_a_addr_i[PS_IDX_W-1:0]];
    assign ent_b = ps_mem[rd_b_addr_i[PS_IDX_W-1:0]];

    // full address is the tag
    assign rd_a_hit_o = ent_a.valid && ent_a.tag == rd_a_addr_i;
    assign rd_b_hit_o = ent_b.valid && ent_b.tag == rd_b_addr_i;
    assign rd_a_sa_o = ent_a.sa;
    assign rd_b_sa_o = ent_b.sa;
    assign rd_b_conf_o = ent_b.conf;

    // a fresh mapping always starts at full confidence
    assign new_a = '{valid: 1'b1, tag: wr_a_addr_i, sa: wr_a_sa_i, conf: conf_t'(CONF_MAX)};
    assign new_b = '{valid: 1'b1, tag: wr_b_addr_i, sa: wr_b_sa_i, conf: wr_b_conf_i};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < PS_ENTRIES; i++) begin
                ps_mem[i].valid <= 1'b0;
            end
        end else begin
            if (wr_a_i) begin
                ps_mem[wr_a_addr_i[PS_IDX_W-1:0]] <= new_a;
            end
            // b last, so it wins on a shared index
            if (wr_b_i) begin
                ps_mem[wr_b_addr_i[PS_IDX_W-1:0]] <= new_b;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sp_amc.sv ====
`default_nettype none

module sp_amc (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            wr0_i,
    input  logic            wr1_i,
    input  isb_pkg::saddr_t wr0_sa_i,
    input  isb_pkg::saddr_t wr1_sa_i,
    input  isb_pkg::paddr_t wr0_pa_i,
    input  isb_pkg::paddr_t wr1_pa_i,
    input  isb_pkg::saddr_t rd_sa_i,
    output logic            rd_v_o,
    output isb_pkg::paddr_t rd_pa_o
);
    import isb_pkg::*;

    localparam int BLK_W = $bits(saddr_t) - SLOT_W;

    logic [SP_SLOTS-1:0] sp_valid [SP_ENTRIES];
    logic [BLK_W-1:0]    sp_tag [SP_ENTRIES];
    paddr_t              sp_pa [SP_ENTRIES][SP_SLOTS];

    logic [SP_SLOTS-1:0] nxt_valid [SP_ENTRIES];
    logic [BLK_W-1:0]    nxt_tag [SP_ENTRIES];

    logic   wr_v [2];
    saddr_t wr_sa [2];
    paddr_t wr_pa [2];

    logic [SP_IDX_W-1:0] rd_idx;
    logic [SLOT_W-1:0]   rd_slot;

    assign wr_v[0] = wr0_i;
    assign wr_v[1] = wr1_i;
    assign wr_sa[0] = wr0_sa_i;
    assign wr_sa[1] = wr1_sa_i;
    assign wr_pa[0] = wr0_pa_i;
    assign wr_pa[1] = wr1_pa_i;

    // port 1 sees port 0's effect, so a shared block keeps both slots
    always_comb begin
        nxt_valid = sp_valid;
        nxt_tag = sp_tag;
        for (int p = 0; p < 2; p++) begin
            if (wr_v[p]) begin
                if (nxt_valid[wr_sa[p][SP_IDX_W+SLOT_W-1:SLOT_W]] == '0
                        || nxt_tag[wr_sa[p][SP_IDX_W+SLOT_W-1:SLOT_W]]
                        != wr_sa[p][$bits(saddr_t)-1:SLOT_W]) begin
                    nxt_valid[wr_sa[p][SP_IDX_W+SLOT_W-1:SLOT_W]] = '0;
                    nxt_tag[wr_sa[p][SP_IDX_W+SLOT_W-1:SLOT_W]] =
                        wr_sa[p][$bits(saddr_t)-1:SLOT_W];
                end
                nxt_valid[wr_sa[p][SP_IDX_W+SLOT_W-1:SLOT_W]][wr_sa[p][SLOT_W-1:0]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < SP_ENTRIES; i++) begin
                sp_valid[i] <= '0;
            end
        end else begin
            sp_valid <= nxt_valid;
        end
    end

    always_ff @(posedge clk) begin
        sp_tag <= nxt_tag;
        for (int p = 0; p < 2; p++) begin
            if (wr_v[p]) begin
                sp_pa[wr_sa[p][SP_IDX_W+SLOT_W-1:SLOT_W]][wr_sa[p][SLOT_W-1:0]] <= wr_pa[p];
            end
        end
    end

    assign rd_idx = rd_sa_i[SP_IDX_W+SLOT_W-1:SLOT_W];
    assign rd_slot = rd_sa_i[SLOT_W-1:0];

    // nothing is mapped past the end of the structural space
    assign rd_v_o = rd_sa_i < SA_SPACE && sp_valid[rd_idx][rd_slot]
                    && sp_tag[rd_idx] == rd_sa_i[$bits(saddr_t)-1:SLOT_W];
    assign rd_pa_o = sp_pa[rd_idx][rd_slot];

endmodule

`default_nettype wire

// ==== stream_predictor.sv ====
`default_nettype none

module stream_predictor (
    input  logic            clk,
    input  logic            rst_i,
    input  logic            access_v_i,
    input  logic            b_hit_i,
    input  isb_pkg::saddr_t b_sa_i,
    output isb_pkg::saddr_t sp_rd_sa_o,
    input  logic            sp_rd_v_i,
    input  isb_pkg::paddr_t sp_rd_pa_i,
    output logic            prefetch_v_o,
    output isb_pkg::paddr_t prefetch_addr_o
);

    logic fire;

    // next structural address in the stream
    assign sp_rd_sa_o = b_sa_i + 1'b1;

    // the sp read already reports not valid past the space
    assign fire = access_v_i && b_hit_i && sp_rd_v_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            prefetch_v_o <= 1'b0;
        end else begin
            prefetch_v_o <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            prefetch_addr_o <= sp_rd_pa_i;
        end
    end

endmodule

`default_nettype wire

// ==== tb_isb.sv ====
`default_nettype none

module tb_isb;
    import isb_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int STIM_CYCLES = 3000;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES + 100;
    localparam int PC_COUNT = 6;
    localparam int SEQ_LEN = 4;

    logic   clk;
    logic   rst_i;
    logic   access_v_i;
    pc_t    access_pc_i;
    paddr_t access_addr_i;
    logic   prefetch_v_o;
    paddr_t prefetch_addr_o;

    int          mismatches;
    int          prefetch_count;
    int          other_errors;
    logic [31:0] rng;
    int          seq_pos [PC_COUNT];
    logic        seq_alt [PC_COUNT];

    isb_top uut (
        .clk            (clk),
        .rst_i          (rst_i),
        .access_v_i     (access_v_i),
        .access_pc_i    (access_pc_i),
        .access_addr_i  (access_addr_i),
        .prefetch_v_o   (prefetch_v_o),
        .prefetch_addr_o(prefetch_addr_o)
    );

    isb_checker u_check (
        .clk             (clk),
        .rst_i           (rst_i),
        .access_v_i      (access_v_i),
        .access_pc_i     (access_pc_i),
        .access_addr_i   (access_addr_i),
        .prefetch_v_i    (prefetch_v_o),
        .prefetch_addr_i (prefetch_addr_o),
        .mismatch_count_o(mismatches),
        .prefetch_count_o(prefetch_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // short repeating sequence per pc, the alternate form changes the successor of position 1
    function automatic paddr_t seq_addr(input int p, input int pos, input logic alt);
        paddr_t a;
        a = paddr_t'(16'h2000 + p * 16'h0147 + pos * 16'h0009);
        if (alt && pos == 2) begin
            a = a + 16'h0a00;
        end
        return a;
    endfunction

    task automatic drive_access;
        int     p;
        logic   v;
        paddr_t addr;
        rng = lcg_next(rng);
        v = rng[31:30] != 2'b00;
        p = rng[29:27] % PC_COUNT;
        if (rng[26:24] == 3'd0) begin
            addr = rng[23:8];
        end else begin
            addr = seq_addr(p, seq_pos[p], seq_alt[p]);
            if (v) begin
                seq_pos[p] = (seq_pos[p] + 1) % SEQ_LEN;
            end
        end
        if (rng[7:3] == 5'd0) begin
            seq_alt[p] = !seq_alt[p];
        end
        access_v_i <= v;
        access_pc_i <= pc_t'(16'h0400 + p * 4);
        access_addr_i <= addr;
    endtask

    task automatic finish_run;
        int total;
        total = mismatches + other_errors;
        $display("errors: %0d mismatches, %0d other, %0d total (%0d prefetches predicted)",
                 mismatches, other_errors, total, prefetch_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        access_v_i = 1'b0;
        access_pc_i = '0;
        access_addr_i = '0;
        other_errors = 0;
        rng = 32'hf491_bb32;
        for (int p = 0; p < PC_COUNT; p++) begin
            seq_pos[p] = 0;
            seq_alt[p] = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(posedge clk);
            drive_access();
        end
        @(posedge clk);
        access_v_i <= 1'b0;
        // let the last prefetch reach the checker
        repeat (3) @(negedge clk);
        if (prefetch_count == 0) begin
            $display("the model predicted no prefetch during the whole run");
            other_errors++;
        end
        finish_run();
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        other_errors++;
        finish_run();
    end

endmodule

`default_nettype wire

// ==== training_unit.sv ====
`default_nettype none

module training_unit (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           access_v_i,
    input  isb_pkg::pc_t   access_pc_i,
    input  isb_pkg::paddr_t access_addr_i,
    output logic           tu_hit_o,
    output isb_pkg::paddr_t tu_last_o
);
    import isb_pkg::*;

    logic [TU_ENTRIES-1:0] tu_valid;
    pc_t                   tu_pc [TU_ENTRIES];
    paddr_t                tu_last [TU_ENTRIES];

    // position 0 is least recent, last position is most recent
    logic [TU_IDX_W-1:0] lru_order [TU_ENTRIES];

    logic                hit;
    logic [TU_IDX_W-1:0] hit_idx;
    logic [TU_IDX_W-1:0] use_idx;
    logic [TU_IDX_W-1:0] use_pos;

    // pc match against all entries
    always_comb begin
        hit = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < TU_ENTRIES; i++) begin
            if (tu_valid[i] && tu_pc[i] == access_pc_i) begin
                hit = 1'b1;
                hit_idx = TU_IDX_W'(i);
            end
        end
    end

    // entry to write, and where it sits in the lru order
    always_comb begin
        use_idx = hit ? hit_idx : lru_order[0];
        use_pos = '0;
        for (int i = 0; i < TU_ENTRIES; i++) begin
            if (lru_order[i] == use_idx) begin
                use_pos = TU_IDX_W'(i);
            end
        end
    end

    assign tu_hit_o = hit;
    assign tu_last_o = tu_last[hit_idx];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tu_valid <= '0;
            for (int i = 0; i < TU_ENTRIES; i++) begin
                lru_order[i] <= TU_IDX_W'(i);
            end
        end else if (access_v_i) begin
            tu_valid[use_idx] <= 1'b1;
            // close the gap and move the used entry to the back
            for (int i = 0; i < TU_ENTRIES - 1; i++) begin
                if (i >= use_pos) begin
                    lru_order[i] <= lru_order[i+1];
                end
            end
            lru_order[TU_ENTRIES-1] <= use_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (access_v_i) begin
            tu_pc[use_idx] <= access_pc_i;
            tu_last[use_idx] <= access_addr_i;
        end
    end

endmodule

`default_nettype wire
